// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_nts_extractor
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/extractor_pkg.sv ====
//------------------------------------------------
// Extractor shared definitions
// Word widths, slot and transmitter state types,
// byte mask helpers for the MAC side
//------------------------------------------------

package extractor_pkg;

  // Packet word geometry
  parameter int DATA_WIDTH = 64;
  parameter int KEEP_WIDTH = DATA_WIDTH / 8;
  parameter int LWB_WIDTH  = 4;

  // Life cycle of one ring slot
  typedef enum logic [1:0] {
    BUF_UNUSED  = 2'b00,
    BUF_WRITING = 2'b01,
    BUF_LOADED  = 2'b10,
    BUF_READING = 2'b11
  } buf_state_e;

  // MAC side sequencing
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_PREFETCH,
    TX_AWAIT_ACK,
    TX_WRITE,
    TX_SILENT
  } tx_state_e;

  // Byte count 1..8 to a mask of that many low bits
  function automatic logic [KEEP_WIDTH-1:0] bytes_to_keep(input logic [LWB_WIDTH-1:0] bytes);
    logic [KEEP_WIDTH-1:0] keep;
    keep = '0;
    for (int i = 0; i < KEEP_WIDTH; i++) begin
      keep[i] = (i < bytes);
    end
    return keep;
  endfunction

  // Output byte k takes input byte 7-k, masked by keep bit k
  function automatic logic [DATA_WIDTH-1:0] byte_reverse_masked(
    input logic [DATA_WIDTH-1:0] data,
    input logic [KEEP_WIDTH-1:0] keep
  );
    logic [DATA_WIDTH-1:0] out;
    for (int k = 0; k < KEEP_WIDTH; k++) begin
      out[8*k +: 8] = keep[k] ? data[8*(KEEP_WIDTH-1-k) +: 8] : 8'h00;
    end
    return out;
  endfunction

endpackage

// ==== dv/extractor_stimulus.txt ====
// Hex columns: word count, last-word bytes, ack delay cycles, gap cycles before next packet
// One packet per line, a zero word count ends the list
0004 8 00 04
0002 1 00 06
0005 3 05 05
0003 2 0C 08
0008 4 01 03
0006 5 00 02
000A 6 07 00
0004 7 14 00
0007 1 1E 00
0002 8 10 00
0009 3 19 00
0005 2 12 00
0003 6 0F 00
0010 4 20 0A
0020 5 02 03
0002 7 00 00
0040 8 03 05
0100 1 00 02
0006 4 08 00
0003 5 00 10

// ==== dv/tb_nts_extractor.sv ====
//------------------------------------------------
// NTS extractor testbench
// Engine FIFO model, MAC model with acknowledge
// delay, word-by-word checker and closing report
//------------------------------------------------

`timescale 1ns/100ps

module tb_nts_extractor;

  localparam int ADDR_WIDTH     = 8;
  localparam int SEL_WIDTH      = 2;
  localparam int MAX_PACKETS    = 32;
  localparam int TIMEOUT_CYCLES = 4000;

  logic        i_clk;
  logic        i_areset;
  logic        i_engine_packet_available;
  logic        i_engine_fifo_empty;
  logic [63:0] i_engine_fifo_rd_data;
  logic  [3:0] i_engine_bytes_last_word;
  logic        o_engine_fifo_rd_en;
  logic        o_engine_packet_read;
  logic        i_mac_tx_ack;
  logic        o_mac_tx_start;
  logic  [7:0] o_mac_tx_data_valid;
  logic [63:0] o_mac_tx_data;

  // Word count, last bytes, ack delay and gap for each packet
  logic [15:0] stim [4*MAX_PACKETS];
  int          num_packets;
  logic [63:0] rng_state;
  logic [63:0] fifo_q[$];
  logic [63:0] exp_q[$];
  int          error_count;
  int          timeout_count;
  int          read_pulses;

  nts_extractor #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .SEL_WIDTH  (SEL_WIDTH)
  ) UUT (
    .i_clk                     (i_clk),
    .i_areset                  (i_areset),
    .i_engine_packet_available (i_engine_packet_available),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_engine_packet_read      (o_engine_packet_read),
    .i_mac_tx_ack              (i_mac_tx_ack),
    .o_mac_tx_start            (o_mac_tx_start),
    .o_mac_tx_data_valid       (o_mac_tx_data_valid),
    .o_mac_tx_data             (o_mac_tx_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // Pulses seen on the engine side
  always @(negedge i_clk) begin
    if (!i_areset && o_engine_packet_read) begin
      read_pulses++;
    end
  end

  //------------------------------------------------
  // Reference helpers
  //------------------------------------------------

  function automatic logic [63:0] xorshift64(input logic [63:0] state);
    logic [63:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // Low bits set for the bytes on the wire
  function automatic logic [7:0] keep_for_bytes(input int bytes);
    return 8'hFF >> (8 - bytes);
  endfunction

  // Wire order reverses the bytes and unused bytes read as zero
  function automatic logic [63:0] expected_mac_word(input logic [63:0] word, input int bytes);
    logic [63:0] swapped;
    swapped = {<<8{word}};
    swapped = swapped & ~({64{1'b1}} << (8 * bytes));
    return swapped;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  // Start, mask and data of one MAC cycle
  task automatic check_word(input int p, input int i, input logic [63:0] word,
                            input int bytes, input logic start);
    check_value($sformatf("packet %0d word %0d start", p, i), start, o_mac_tx_start);
    check_value($sformatf("packet %0d word %0d valid", p, i), keep_for_bytes(bytes),
                o_mac_tx_data_valid);
    check_value($sformatf("packet %0d word %0d data", p, i),
                expected_mac_word(word, bytes), o_mac_tx_data);
  endtask

  //------------------------------------------------
  // Engine FIFO model
  //------------------------------------------------

  // Head moves on every edge with the read enable high
  task automatic pop_fifo_word();
    assert (fifo_q.size() > 0) else begin
      $display("FIFO read enable raised while the FIFO model was empty");
      error_count++;
    end
    if (fifo_q.size() > 0) begin
      fifo_q.delete(0);
    end
    if (fifo_q.size() == 0) begin
      i_engine_fifo_empty       <= 1'b1;
      i_engine_packet_available <= 1'b0;
      i_engine_fifo_rd_data     <= '0;
    end else begin
      i_engine_fifo_rd_data <= fifo_q[0];
    end
  endtask

  // Loads one packet at a time and waits for its packet read and gap
  task automatic feed_engine();
    int   p;
    int   i;
    int   cyc;
    logic done;
    logic read_seen;
    logic rd_en_seen;
    @(posedge i_clk);
    for (p = 0; p < num_packets; p++) begin
      for (i = 0; i < int'(stim[4*p]); i++) begin
        rng_state = xorshift64(rng_state);
        fifo_q.push_back(rng_state);
        exp_q.push_back(rng_state);
      end
      i_engine_fifo_rd_data     <= fifo_q[0];
      i_engine_fifo_empty       <= 1'b0;
      i_engine_packet_available <= 1'b1;
      i_engine_bytes_last_word  <= stim[4*p+1][3:0];
      done = 1'b0;
      for (cyc = 0; cyc < TIMEOUT_CYCLES && !done; cyc++) begin
        // Sample at the falling edge, act at the next rising edge
        @(negedge i_clk);
        read_seen  = o_engine_packet_read;
        rd_en_seen = o_engine_fifo_rd_en;
        @(posedge i_clk);
        if (read_seen) begin
          done = 1'b1;
        end else if (rd_en_seen) begin
          pop_fifo_word();
        end
      end
      if (!done) begin
        $display("Timed out waiting for the engine packet read of packet %0d", p);
        timeout_count++;
        break;
      end
      repeat (int'(stim[4*p+3])) @(posedge i_clk);
    end
  endtask

  //------------------------------------------------
  // MAC model and checker
  //------------------------------------------------

  task automatic watch_mac();
    int          p;
    int          i;
    int          n;
    int          bytes;
    int          cyc;
    logic        seen;
    logic [63:0] word;
    for (p = 0; p < num_packets; p++) begin
      n     = int'(stim[4*p]);
      bytes = int'(stim[4*p+1]);
      seen  = 1'b0;
      for (cyc = 0; cyc < TIMEOUT_CYCLES && !seen; cyc++) begin
        @(negedge i_clk);
        seen = o_mac_tx_start;
      end
      if (!seen) begin
        $display("Timed out waiting for the MAC start of packet %0d", p);
        timeout_count++;
        break;
      end
      if (exp_q.size() < n) begin
        $display("Packet %0d started before all of its words reached the engine", p);
        error_count++;
        break;
      end
      // Word 0 holds from the start strobe until the acknowledge
      word = exp_q.pop_front();
      check_word(p, 0, word, 8, 1'b1);
      repeat (int'(stim[4*p+2])) begin
        @(negedge i_clk);
        check_word(p, 0, word, 8, 1'b0);
      end
      @(posedge i_clk);
      i_mac_tx_ack <= 1'b1;
      @(negedge i_clk);
      check_word(p, 0, word, 8, 1'b0);
      @(posedge i_clk);
      i_mac_tx_ack <= 1'b0;
      // Remaining words back to back
      for (i = 1; i < n; i++) begin
        @(negedge i_clk);
        word = exp_q.pop_front();
        check_word(p, i, word, (i == n - 1) ? bytes : 8, 1'b0);
      end
      // Silent cycle
      @(negedge i_clk);
      check_word(p, n, '0, 0, 1'b0);
    end
  endtask

  //------------------------------------------------
  // Main sequence
  //------------------------------------------------

  initial begin
    i_areset                  = 1'b1;
    i_engine_packet_available = 1'b0;
    i_engine_fifo_empty       = 1'b1;
    i_engine_fifo_rd_data     = '0;
    i_engine_bytes_last_word  = '0;
    i_mac_tx_ack              = 1'b0;
    rng_state                 = 64'd52;
    error_count               = 0;
    timeout_count             = 0;
    read_pulses               = 0;
    for (int k = 0; k < 4*MAX_PACKETS; k++) begin
      stim[k] = '0;
    end
    $readmemh("dv/extractor_stimulus.txt", stim);
    // A zero word count ends the list
    num_packets = 0;
    while (num_packets < MAX_PACKETS && stim[4*num_packets] != '0) begin
      num_packets++;
    end
    if (num_packets == 0) begin
      $display("The stimulus file held no packets");
      error_count++;
    end

    repeat (16) @(posedge i_clk);
    i_areset <= 1'b0;

    // Quiet outputs before the first packet
    repeat (8) begin
      @(negedge i_clk);
      check_value("idle start", 0, o_mac_tx_start);
      check_value("idle valid", 0, o_mac_tx_data_valid);
      check_value("idle fifo read", 0, o_engine_fifo_rd_en);
    end

    fork
      feed_engine();
      watch_mac();
    join

    check_value("packet read pulses", num_packets, read_pulses);
    check_value("fifo words left", 0, fifo_q.size());
    check_value("expected words left", 0, exp_q.size());

    $display("Errors: %0d check failures, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/extractor_pkg.sv
verilog/engine_writer.sv
verilog/buffer_ring.sv
mac_tx/mac_transmitter.sv
verilog/nts_extractor.sv
dv/tb_nts_extractor.sv

// ==== mac_tx/mac_transmitter.sv ====
//------------------------------------------------
// MAC transmitter
// Sends the oldest loaded slot: start strobe, wait
// for acknowledge, stream words, one silent cycle
//------------------------------------------------

`timescale 1ns/100ps

module mac_transmitter #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,

  // Ring side
  input  extractor_pkg::buf_state_e            i_rd_state,
  input  logic [extractor_pkg::DATA_WIDTH-1:0] i_rd_data,
  input  logic                [ADDR_WIDTH-1:0] i_rd_last_offset,
  input  logic  [extractor_pkg::LWB_WIDTH-1:0] i_rd_bytes_last,
  output logic                [ADDR_WIDTH-1:0] o_rd_offset,
  output logic                                 o_mark_reading,
  output logic                                 o_mark_free,

  // MAC side
  input  logic                                 i_mac_tx_ack,
  output logic                                 o_mac_tx_start,
  output logic [extractor_pkg::KEEP_WIDTH-1:0] o_mac_tx_data_valid,
  output logic [extractor_pkg::DATA_WIDTH-1:0] o_mac_tx_data
);

  extractor_pkg::tx_state_e tx_state_reg;
  extractor_pkg::tx_state_e tx_state_new;

  // Index of the word sitting in i_rd_data
  logic [ADDR_WIDTH-1:0] rd_addr_reg;
  logic [ADDR_WIDTH-1:0] rd_addr_new;

  logic                                 start_new;
  logic [extractor_pkg::KEEP_WIDTH-1:0] valid_reg;
  logic [extractor_pkg::KEEP_WIDTH-1:0] valid_new;
  logic [extractor_pkg::DATA_WIDTH-1:0] word_reg;
  logic                                 word_we;
  logic                                 load_word;
  logic                                 last_reg;
  logic                                 last_new;

  //------------------------------------------------
  // Sequencing
  //------------------------------------------------

  always_comb begin
    tx_state_new   = tx_state_reg;
    rd_addr_new    = rd_addr_reg;
    start_new      = 1'b0;
    valid_new      = valid_reg;
    word_we        = 1'b0;
    load_word      = 1'b0;
    last_new       = last_reg;
    o_mark_reading = 1'b0;
    o_mark_free    = 1'b0;
    case (tx_state_reg)
      extractor_pkg::TX_IDLE: begin
        valid_new = '0;
        if (i_rd_state == extractor_pkg::BUF_LOADED) begin
          o_mark_reading = 1'b1;
          tx_state_new   = extractor_pkg::TX_PREFETCH;
        end
      end
      extractor_pkg::TX_PREFETCH: begin
        // Word 0 is ready, present it with the start strobe
        start_new    = 1'b1;
        valid_new    = '1;
        word_we      = 1'b1;
        last_new     = 1'b0;
        rd_addr_new  = rd_addr_reg + 1'b1;
        tx_state_new = extractor_pkg::TX_AWAIT_ACK;
      end
      extractor_pkg::TX_AWAIT_ACK: begin
        // Word 0 holds until the MAC accepts it
        load_word = i_mac_tx_ack;
      end
      extractor_pkg::TX_WRITE: begin
        if (last_reg) begin
          valid_new    = '0;
          tx_state_new = extractor_pkg::TX_SILENT;
        end else begin
          load_word = 1'b1;
        end
      end
      extractor_pkg::TX_SILENT: begin
        o_mark_free  = 1'b1;
        valid_new    = '0;
        rd_addr_new  = '0;
        tx_state_new = extractor_pkg::TX_IDLE;
      end
      default: begin
        valid_new    = '0;
        rd_addr_new  = '0;
        tx_state_new = extractor_pkg::TX_IDLE;
      end
    endcase
    // Move the prefetched word to the outputs and read one further
    if (load_word) begin
      word_we      = 1'b1;
      rd_addr_new  = rd_addr_reg + 1'b1;
      tx_state_new = extractor_pkg::TX_WRITE;
      if (rd_addr_reg == i_rd_last_offset) begin
        valid_new = extractor_pkg::bytes_to_keep(i_rd_bytes_last);
        last_new  = 1'b1;
      end else begin
        valid_new = '1;
        last_new  = 1'b0;
      end
    end
  end

  // Ring returns data one cycle after the offset, so ask for the next index
  assign o_rd_offset = rd_addr_new;

  //------------------------------------------------
  // Registers
  //------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      tx_state_reg   <= extractor_pkg::TX_IDLE;
      rd_addr_reg    <= '0;
      o_mac_tx_start <= 1'b0;
      valid_reg      <= '0;
      last_reg       <= 1'b0;
    end else begin
      tx_state_reg   <= tx_state_new;
      rd_addr_reg    <= rd_addr_new;
      o_mac_tx_start <= start_new;
      valid_reg      <= valid_new;
      last_reg       <= last_new;
    end
  end

  always_ff @(posedge i_clk) begin
    if (word_we) begin
      word_reg <= i_rd_data;
    end
  end

  // Zero mask also zeroes the data, which gives the silent cycle
  assign o_mac_tx_data_valid = valid_reg;
  assign o_mac_tx_data       = extractor_pkg::byte_reverse_masked(word_reg, valid_reg);

endmodule

// ==== verilog/buffer_ring.sv ====
//------------------------------------------------
// Buffer ring
// Packet memory, per-slot state table and the two
// slot pointers shared by writer and transmitter
//------------------------------------------------

`timescale 1ns/100ps

module buffer_ring #(
  parameter int ADDR_WIDTH = 8,
  parameter int SEL_WIDTH  = 2
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,

  // Writer side
  input  logic                                 i_wr_en,
  input  logic                [ADDR_WIDTH-1:0] i_wr_offset,
  input  logic [extractor_pkg::DATA_WIDTH-1:0] i_wr_data,
  input  logic  [extractor_pkg::LWB_WIDTH-1:0] i_wr_bytes_last,
  input  logic                                 i_mark_writing,
  input  logic                                 i_mark_loaded,
  output extractor_pkg::buf_state_e            o_wr_state,

  // Transmitter side
  input  logic                [ADDR_WIDTH-1:0] i_rd_offset,
  input  logic                                 i_mark_reading,
  input  logic                                 i_mark_free,
  output extractor_pkg::buf_state_e            o_rd_state,
  output logic [extractor_pkg::DATA_WIDTH-1:0] o_rd_data,
  output logic                [ADDR_WIDTH-1:0] o_rd_last_offset,
  output logic  [extractor_pkg::LWB_WIDTH-1:0] o_rd_bytes_last
);

  localparam int NUM_BUFS = 1 << SEL_WIDTH;
  localparam int WORDS    = 1 << ADDR_WIDTH;

  logic [extractor_pkg::DATA_WIDTH-1:0] mem [NUM_BUFS][WORDS];

  extractor_pkg::buf_state_e           buf_state      [NUM_BUFS];
  logic               [ADDR_WIDTH-1:0] buf_last_offset[NUM_BUFS];
  logic [extractor_pkg::LWB_WIDTH-1:0] buf_bytes_last [NUM_BUFS];

  logic [SEL_WIDTH-1:0] wr_sel;
  logic [SEL_WIDTH-1:0] rd_sel;

  //------------------------------------------------
  // Packet memory
  //------------------------------------------------

  // Write port at the writer slot, read port at the reader slot
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[wr_sel][i_wr_offset] <= i_wr_data;
    end
    o_rd_data <= mem[rd_sel][i_rd_offset];
  end

  // Last written offset and byte count of each slot
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      buf_last_offset[wr_sel] <= i_wr_offset;
    end
    if (i_mark_writing) begin
      buf_bytes_last[wr_sel] <= i_wr_bytes_last;
    end
  end

  //------------------------------------------------
  // Slot life cycle and pointers
  //------------------------------------------------

  // Each strobe needs a distinct slot state, so the two sides never collide
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < NUM_BUFS; i++) begin
        buf_state[i] <= extractor_pkg::BUF_UNUSED;
      end
      wr_sel <= '0;
      rd_sel <= '0;
    end else begin
      if (i_mark_writing) begin
        buf_state[wr_sel] <= extractor_pkg::BUF_WRITING;
      end
      if (i_mark_loaded) begin
        buf_state[wr_sel] <= extractor_pkg::BUF_LOADED;
        wr_sel <= wr_sel + 1'b1;
      end
      if (i_mark_reading) begin
        buf_state[rd_sel] <= extractor_pkg::BUF_READING;
      end
      if (i_mark_free) begin
        buf_state[rd_sel] <= extractor_pkg::BUF_UNUSED;
        rd_sel <= rd_sel + 1'b1;
      end
    end
  end

  assign o_wr_state       = buf_state[wr_sel];
  assign o_rd_state       = buf_state[rd_sel];
  assign o_rd_last_offset = buf_last_offset[rd_sel];
  assign o_rd_bytes_last  = buf_bytes_last[rd_sel];

endmodule

// ==== verilog/engine_writer.sv ====
//------------------------------------------------
// Engine writer
// Moves one packet from the show-ahead engine FIFO
// into the ring slot currently open for writing
//------------------------------------------------

`timescale 1ns/100ps

module engine_writer #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,

  input  logic                                 i_engine_packet_available,
  input  logic                                 i_engine_fifo_empty,
  input  logic [extractor_pkg::DATA_WIDTH-1:0] i_engine_fifo_rd_data,
  input  logic  [extractor_pkg::LWB_WIDTH-1:0] i_engine_bytes_last_word,
  output logic                                 o_engine_fifo_rd_en,
  output logic                                 o_engine_packet_read,

  input  extractor_pkg::buf_state_e            i_wr_state,
  output logic                                 o_wr_en,
  output logic                [ADDR_WIDTH-1:0] o_wr_offset,
  output logic [extractor_pkg::DATA_WIDTH-1:0] o_wr_data,
  output logic  [extractor_pkg::LWB_WIDTH-1:0] o_wr_bytes_last,
  output logic                                 o_mark_writing,
  output logic                                 o_mark_loaded
);

  //------------------------------------------------
  // Packet start and end decisions
  //------------------------------------------------

  logic                  slot_free;
  logic                  slot_writing;
  logic                  start_packet;
  logic                  copy_word;
  logic                  end_packet;
  logic [ADDR_WIDTH-1:0] offset_reg;

  assign slot_free    = (i_wr_state == extractor_pkg::BUF_UNUSED);
  assign slot_writing = (i_wr_state == extractor_pkg::BUF_WRITING);

  // Claim only when a whole packet waits and data is at the head
  assign start_packet = slot_free && i_engine_packet_available && !i_engine_fifo_empty;

  // One head word per cycle while the slot is open
  assign copy_word = slot_writing && !i_engine_fifo_empty;

  // FIFO ran dry inside the slot, so the packet is complete
  assign end_packet = slot_writing && i_engine_fifo_empty;

  //------------------------------------------------
  // Word offset inside the slot
  //------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      offset_reg <= '0;
    end else if (start_packet) begin
      offset_reg <= '0;
    end else if (copy_word) begin
      offset_reg <= offset_reg + 1'b1;
    end
  end

  // Pop and write happen on the same edge
  assign o_engine_fifo_rd_en = copy_word;
  assign o_wr_en             = copy_word;
  assign o_wr_offset         = offset_reg;
  assign o_wr_data           = i_engine_fifo_rd_data;

  // Byte count is latched by the ring together with the claim
  assign o_wr_bytes_last = i_engine_bytes_last_word;
  assign o_mark_writing  = start_packet;

  assign o_mark_loaded        = end_packet;
  assign o_engine_packet_read = end_packet;

endmodule

// ==== verilog/nts_extractor.sv ====
//------------------------------------------------
// NTS extractor top level
// Engine FIFO to MAC transmit through a buffer ring
//------------------------------------------------

`timescale 1ns/100ps

module nts_extractor #(
  parameter int ADDR_WIDTH = 8,
  parameter int SEL_WIDTH  = 2
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,

  input  logic                                 i_engine_packet_available,
  input  logic                                 i_engine_fifo_empty,
  input  logic [extractor_pkg::DATA_WIDTH-1:0] i_engine_fifo_rd_data,
  input  logic  [extractor_pkg::LWB_WIDTH-1:0] i_engine_bytes_last_word,
  output logic                                 o_engine_fifo_rd_en,
  output logic                                 o_engine_packet_read,

  input  logic                                 i_mac_tx_ack,
  output logic                                 o_mac_tx_start,
  output logic [extractor_pkg::KEEP_WIDTH-1:0] o_mac_tx_data_valid,
  output logic [extractor_pkg::DATA_WIDTH-1:0] o_mac_tx_data
);

  // Writer to ring
  logic                                 wr_en;
  logic                [ADDR_WIDTH-1:0] wr_offset;
  logic [extractor_pkg::DATA_WIDTH-1:0] wr_data;
  logic  [extractor_pkg::LWB_WIDTH-1:0] wr_bytes_last;
  logic                                 mark_writing;
  logic                                 mark_loaded;
  extractor_pkg::buf_state_e            wr_state;

  // Transmitter to ring
  logic                [ADDR_WIDTH-1:0] rd_offset;
  logic                                 mark_reading;
  logic                                 mark_free;
  extractor_pkg::buf_state_e            rd_state;
  logic [extractor_pkg::DATA_WIDTH-1:0] rd_data;
  logic                [ADDR_WIDTH-1:0] rd_last_offset;
  logic  [extractor_pkg::LWB_WIDTH-1:0] rd_bytes_last;

  engine_writer #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_writer (
    .i_clk                     (i_clk),
    .i_areset                  (i_areset),
    .i_engine_packet_available (i_engine_packet_available),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_engine_packet_read      (o_engine_packet_read),
    .i_wr_state                (wr_state),
    .o_wr_en                   (wr_en),
    .o_wr_offset               (wr_offset),
    .o_wr_data                 (wr_data),
    .o_wr_bytes_last           (wr_bytes_last),
    .o_mark_writing            (mark_writing),
    .o_mark_loaded             (mark_loaded)
  );

  buffer_ring #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .SEL_WIDTH  (SEL_WIDTH)
  ) u_ring (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_wr_en          (wr_en),
    .i_wr_offset      (wr_offset),
    .i_wr_data        (wr_data),
    .i_wr_bytes_last  (wr_bytes_last),
    .i_mark_writing   (mark_writing),
    .i_mark_loaded    (mark_loaded),
    .o_wr_state       (wr_state),
    .i_rd_offset      (rd_offset),
    .i_mark_reading   (mark_reading),
    .i_mark_free      (mark_free),
    .o_rd_state       (rd_state),
    .o_rd_data        (rd_data),
    .o_rd_last_offset (rd_last_offset),
    .o_rd_bytes_last  (rd_bytes_last)
  );

  mac_transmitter #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_transmitter (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_rd_state          (rd_state),
    .i_rd_data           (rd_data),
    .i_rd_last_offset    (rd_last_offset),
    .i_rd_bytes_last     (rd_bytes_last),
    .o_rd_offset         (rd_offset),
    .o_mark_reading      (mark_reading),
    .o_mark_free         (mark_free),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_mac_tx_start      (o_mac_tx_start),
    .o_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_mac_tx_data       (o_mac_tx_data)
  );

endmodule
